// File: Makefile
VERILATOR  ?= verilator
TOP        ?= ex1_tb
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: src/ex1_stage.sv
`include "ex_settings.svh"

module ex1_stage (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  flush_i,
    input  logic [`EX_DATA_W-1:0] pc0_i,
    input  logic [`EX_DATA_W-1:0] pc1_i,
    input  logic                  valid0_i,
    input  logic                  valid1_i,
    input  ex_pkg::alu_op_e       alu_op0_i,
    input  ex_pkg::alu_op_e       alu_op1_i,
    input  ex_pkg::src1_sel_e     src1_sel0_i,
    input  ex_pkg::src1_sel_e     src1_sel1_i,
    input  ex_pkg::src2_sel_e     src2_sel0_i,
    input  ex_pkg::src2_sel_e     src2_sel1_i,
    input  logic [`EX_DATA_W-1:0] imm0_i,
    input  logic [`EX_DATA_W-1:0] imm1_i,
    input  logic [`EX_REG_W-1:0]  rj0_i,
    input  logic [`EX_REG_W-1:0]  rk0_i,
    input  logic [`EX_REG_W-1:0]  rj1_i,
    input  logic [`EX_REG_W-1:0]  rk1_i,
    input  logic [`EX_DATA_W-1:0] rj0_data_i,
    input  logic [`EX_DATA_W-1:0] rk0_data_i,
    input  logic [`EX_DATA_W-1:0] rj1_data_i,
    input  logic [`EX_DATA_W-1:0] rk1_data_i,
    input  logic [`EX_REG_W-1:0]  e2_rd0_i,
    input  logic [`EX_REG_W-1:0]  e2_rd1_i,
    input  logic [`EX_DATA_W-1:0] e2_data0_i,
    input  logic [`EX_DATA_W-1:0] e2_data1_i,
    input  logic                  e2_valid0_i,
    input  logic                  e2_valid1_i,
    input  logic [`EX_REG_W-1:0]  wb_rd0_i,
    input  logic [`EX_REG_W-1:0]  wb_rd1_i,
    input  logic [`EX_DATA_W-1:0] wb_data0_i,
    input  logic [`EX_DATA_W-1:0] wb_data1_i,
    input  logic                  wb_valid0_i,
    input  logic                  wb_valid1_i,
    input  logic [`EX_DATA_W-1:0] tid_i,
    input  logic [63:0]           stable_counter_i,
    input  ex_pkg::br_op_e        br_op0_i,
    input  logic                  predict_taken_i,
    input  logic [`EX_DATA_W-1:0] predict_pc_i,
    input  ex_pkg::div_op_e       div_op0_i,
    output logic [`EX_DATA_W-1:0] result0_o,
    output logic [`EX_DATA_W-1:0] result1_o,
    output logic                  result0_valid_o,
    output logic                  result1_valid_o,
    output logic                  fact_taken_o,
    output logic [`EX_DATA_W-1:0] fact_tpc_o,
    output logic                  predict_dir_fail_o,
    output logic                  predict_addr_fail_o,
    output logic [`EX_DATA_W-1:0] div_result_o,
    output logic                  div_done_o,
    output logic                  stall_o
);

    localparam int W = `EX_DATA_W;

    logic [W-1:0] rj0_fwd;
    logic [W-1:0] rk0_fwd;
    logic [W-1:0] rj1_fwd;
    logic [W-1:0] rk1_fwd;
    logic [W-1:0] a0;
    logic [W-1:0] b0;
    logic [W-1:0] a1;
    logic [W-1:0] b1;
    logic [W-1:0] y0;
    logic [W-1:0] y1;
    logic         div_busy;
    logic         div_req;
    logic         div_start;

    function automatic logic [W-1:0] src1_mux(
        input ex_pkg::src1_sel_e sel,
        input logic [W-1:0]      rf,
        input logic [W-1:0]      pc,
        input logic [W-1:0]      tid
    );
        case (sel)
            ex_pkg::src1_rf:   return rf;
            ex_pkg::src1_pc:   return pc;
            ex_pkg::src1_zero: return '0;
            default:           return tid;
        endcase
    endfunction

    function automatic logic [W-1:0] src2_mux(
        input ex_pkg::src2_sel_e sel,
        input logic [W-1:0]      rf,
        input logic [W-1:0]      imm,
        input logic [63:0]       cnt
    );
        case (sel)
            ex_pkg::src2_rf:     return rf;
            ex_pkg::src2_imm:    return imm;
            ex_pkg::src2_cnt_lo: return cnt[31:0];
            default:             return cnt[63:32];   // rdcntvh
        endcase
    endfunction

    ex_forward u_fwd0 (
        .rj_i(rj0_i), .rk_i(rk0_i), .rj_data_i(rj0_data_i), .rk_data_i(rk0_data_i),
        .e2_rd0_i(e2_rd0_i), .e2_rd1_i(e2_rd1_i),
        .e2_data0_i(e2_data0_i), .e2_data1_i(e2_data1_i),
        .e2_valid0_i(e2_valid0_i), .e2_valid1_i(e2_valid1_i),
        .wb_rd0_i(wb_rd0_i), .wb_rd1_i(wb_rd1_i),
        .wb_data0_i(wb_data0_i), .wb_data1_i(wb_data1_i),
        .wb_valid0_i(wb_valid0_i), .wb_valid1_i(wb_valid1_i),
        .rj_data_o(rj0_fwd), .rk_data_o(rk0_fwd)
    );

    ex_forward u_fwd1 (
        .rj_i(rj1_i), .rk_i(rk1_i), .rj_data_i(rj1_data_i), .rk_data_i(rk1_data_i),
        .e2_rd0_i(e2_rd0_i), .e2_rd1_i(e2_rd1_i),
        .e2_data0_i(e2_data0_i), .e2_data1_i(e2_data1_i),
        .e2_valid0_i(e2_valid0_i), .e2_valid1_i(e2_valid1_i),
        .wb_rd0_i(wb_rd0_i), .wb_rd1_i(wb_rd1_i),
        .wb_data0_i(wb_data0_i), .wb_data1_i(wb_data1_i),
        .wb_valid0_i(wb_valid0_i), .wb_valid1_i(wb_valid1_i),
        .rj_data_o(rj1_fwd), .rk_data_o(rk1_fwd)
    );

    assign a0 = src1_mux(src1_sel0_i, rj0_fwd, pc0_i, tid_i);
    assign b0 = src2_mux(src2_sel0_i, rk0_fwd, imm0_i, stable_counter_i);
    assign a1 = src1_mux(src1_sel1_i, rj1_fwd, pc1_i, tid_i);
    assign b1 = src2_mux(src2_sel1_i, rk1_fwd, imm1_i, stable_counter_i);

    ex_alu u_alu0 (.op_i(alu_op0_i), .a_i(a0), .b_i(b0), .y_o(y0));
    ex_alu u_alu1 (.op_i(alu_op1_i), .a_i(a1), .b_i(b1), .y_o(y1));

    ex_branch u_branch (
        .valid_i(valid0_i), .op_i(br_op0_i), .pc_i(pc0_i), .imm_i(imm0_i),
        .src1_i(rj0_fwd), .src2_i(rk0_fwd),
        .predict_taken_i(predict_taken_i), .predict_pc_i(predict_pc_i),
        .fact_taken_o(fact_taken_o), .fact_tpc_o(fact_tpc_o),
        .predict_dir_fail_o(predict_dir_fail_o), .predict_addr_fail_o(predict_addr_fail_o)
    );

    assign div_req   = valid0_i && (div_op0_i != ex_pkg::div_none);
    assign div_start = div_req && !div_busy && !flush_i;

    ex_divider u_div (
        .clk(clk), .arst_n_i(arst_n_i), .flush_i(flush_i), .start_i(div_start),
        .op_i(div_op0_i), .dividend_i(rj0_fwd), .divisor_i(rk0_fwd),
        .busy_o(div_busy), .done_o(div_done_o), .result_o(div_result_o)
    );

    assign stall_o = div_req && !div_done_o;   // hold issue until the done cycle

    // link value for branches
    assign result0_o = (br_op0_i != ex_pkg::br_none) ? pc0_i + W'(4) : y0;
    assign result1_o = y1;

    assign result0_valid_o = valid0_i && !flush_i && !stall_o;
    assign result1_valid_o = valid1_i && !flush_i && !stall_o;

endmodule

// File: src/ex_alu.sv
`include "ex_settings.svh"

module ex_alu (
    input  ex_pkg::alu_op_e       op_i,
    input  logic [`EX_DATA_W-1:0] a_i,
    input  logic [`EX_DATA_W-1:0] b_i,
    output logic [`EX_DATA_W-1:0] y_o
);

    logic [4:0]            shamt;
    logic [`EX_DATA_W-1:0] sum;
    logic [`EX_DATA_W-1:0] diff;
    logic                  lt_s;
    logic                  lt_u;

    assign shamt = b_i[4:0];
    assign sum   = a_i + b_i;
    assign diff  = a_i - b_i;
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (op_i)
            ex_pkg::alu_add:  y_o = sum;
            ex_pkg::alu_sub:  y_o = diff;
            ex_pkg::alu_slt:  y_o = {{(`EX_DATA_W-1){1'b0}}, lt_s};
            ex_pkg::alu_sltu: y_o = {{(`EX_DATA_W-1){1'b0}}, lt_u};
            ex_pkg::alu_and:  y_o = a_i & b_i;
            ex_pkg::alu_or:   y_o = a_i | b_i;
            ex_pkg::alu_nor:  y_o = ~(a_i | b_i);
            ex_pkg::alu_xor:  y_o = a_i ^ b_i;
            ex_pkg::alu_sll:  y_o = a_i << shamt;
            ex_pkg::alu_srl:  y_o = a_i >> shamt;
            ex_pkg::alu_sra:  y_o = $signed(a_i) >>> shamt;   // keep sign
            default:          y_o = '0;   // unused encodings
        endcase
    end

endmodule

// File: src/ex_branch.sv
`include "ex_settings.svh"

module ex_branch (
    input  logic                  valid_i,
    input  ex_pkg::br_op_e        op_i,
    input  logic [`EX_DATA_W-1:0] pc_i,
    input  logic [`EX_DATA_W-1:0] imm_i,
    input  logic [`EX_DATA_W-1:0] src1_i,
    input  logic [`EX_DATA_W-1:0] src2_i,
    input  logic                  predict_taken_i,
    input  logic [`EX_DATA_W-1:0] predict_pc_i,
    output logic                  fact_taken_o,
    output logic [`EX_DATA_W-1:0] fact_tpc_o,
    output logic                  predict_dir_fail_o,
    output logic                  predict_addr_fail_o
);

    logic                  active;
    logic                  cond;
    logic [`EX_DATA_W-1:0] base;
    logic [`EX_DATA_W-1:0] target;

    assign active = valid_i && (op_i != ex_pkg::br_none);

    always_comb begin
        case (op_i)
            ex_pkg::br_beq:  cond = (src1_i == src2_i);
            ex_pkg::br_bne:  cond = (src1_i != src2_i);
            ex_pkg::br_blt:  cond = ($signed(src1_i) < $signed(src2_i));
            ex_pkg::br_bge:  cond = ($signed(src1_i) >= $signed(src2_i));
            ex_pkg::br_bltu: cond = (src1_i < src2_i);
            ex_pkg::br_bgeu: cond = (src1_i >= src2_i);
            ex_pkg::br_b,
            ex_pkg::br_jirl: cond = 1'b1;   // unconditional
            default:         cond = 1'b0;
        endcase
    end

    assign base   = (op_i == ex_pkg::br_jirl) ? src1_i : pc_i;
    assign target = base + imm_i;

    assign fact_taken_o        = active && cond;
    assign fact_tpc_o          = active ? target : '0;
    assign predict_dir_fail_o  = active && (cond != predict_taken_i);
    // right direction, wrong place
    assign predict_addr_fail_o = active && cond && predict_taken_i && (target != predict_pc_i);

    always_comb begin
        a_addr_fail_taken: assert final (!predict_addr_fail_o || fact_taken_o)
            else $error("address mispredict on a branch that is not taken");
    end

endmodule

// File: src/ex_divider.sv
`include "ex_settings.svh"

module ex_divider (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  flush_i,
    input  logic                  start_i,
    input  ex_pkg::div_op_e       op_i,
    input  logic [`EX_DATA_W-1:0] dividend_i,
    input  logic [`EX_DATA_W-1:0] divisor_i,
    output logic                  busy_o,
    output logic                  done_o,
    output logic [`EX_DATA_W-1:0] result_o
);

    localparam int W     = `EX_DATA_W;
    localparam int CNT_W = $clog2(`EX_DIV_STEPS + 1);

    ex_pkg::div_state_e state_q;
    logic [CNT_W-1:0]   cnt_q;
    logic               last_step;

    logic               is_signed;
    logic               a_neg;
    logic               b_neg;
    logic [W-1:0]       a_mag;
    logic [W-1:0]       b_mag;

    logic [W-1:0]       dvsr_q;
    logic [W-1:0]       rem_q;
    logic [W-1:0]       quo_q;    // dividend bits shift out, quotient bits shift in
    logic               q_neg_q;
    logic               r_neg_q;
    logic               dvz_q;
    logic               want_rem_q;
    logic [W-1:0]       result_q;

    logic [W:0]         shifted;
    logic [W:0]         trial;
    logic [W-1:0]       quo_fix;
    logic [W-1:0]       rem_fix;

    assign is_signed = (op_i == ex_pkg::div_div) || (op_i == ex_pkg::div_mod);
    assign a_neg     = is_signed && dividend_i[W-1];
    assign b_neg     = is_signed && divisor_i[W-1];
    assign a_mag     = a_neg ? -dividend_i : dividend_i;
    assign b_mag     = b_neg ? -divisor_i : divisor_i;

    assign last_step = (cnt_q == CNT_W'(`EX_DIV_STEPS));
    assign shifted   = {rem_q, quo_q[W-1]};
    assign trial     = shifted - {1'b0, dvsr_q};

    assign quo_fix = dvz_q ? '1 : (q_neg_q ? -quo_q : quo_q);
    assign rem_fix = r_neg_q ? -rem_q : rem_q;   // follows dividend sign

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ex_pkg::div_idle;
            cnt_q   <= '0;
        end else if (flush_i) begin
            state_q <= ex_pkg::div_idle;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ex_pkg::div_idle: begin
                    if (start_i) begin
                        state_q <= ex_pkg::div_run;
                        cnt_q   <= '0;
                    end
                end
                ex_pkg::div_run: begin
                    if (last_step) state_q <= ex_pkg::div_done;
                    else           cnt_q   <= cnt_q + 1'b1;
                end
                default: state_q <= ex_pkg::div_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ex_pkg::div_idle && start_i) begin
            dvsr_q     <= b_mag;
            rem_q      <= '0;
            quo_q      <= a_mag;
            q_neg_q    <= a_neg ^ b_neg;
            r_neg_q    <= a_neg;
            dvz_q      <= (divisor_i == '0);
            want_rem_q <= (op_i == ex_pkg::div_mod) || (op_i == ex_pkg::div_modu);
        end else if (state_q == ex_pkg::div_run) begin
            if (last_step) begin
                result_q <= want_rem_q ? rem_fix : quo_fix;   // sign fix-up cycle
            end else if (!trial[W]) begin
                rem_q <= trial[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b1};
            end else begin
                rem_q <= shifted[W-1:0];   // restore
                quo_q <= {quo_q[W-2:0], 1'b0};
            end
        end
    end

    assign busy_o   = (state_q != ex_pkg::div_idle);
    assign done_o   = (state_q == ex_pkg::div_done);
    assign result_o = result_q;

    a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        done_o |=> !done_o);

    a_start_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
        start_i |-> !busy_o);

endmodule

// File: src/ex_forward.sv
`include "ex_settings.svh"

module ex_forward (
    input  logic [`EX_REG_W-1:0]  rj_i,
    input  logic [`EX_REG_W-1:0]  rk_i,
    input  logic [`EX_DATA_W-1:0] rj_data_i,
    input  logic [`EX_DATA_W-1:0] rk_data_i,
    input  logic [`EX_REG_W-1:0]  e2_rd0_i,
    input  logic [`EX_REG_W-1:0]  e2_rd1_i,
    input  logic [`EX_DATA_W-1:0] e2_data0_i,
    input  logic [`EX_DATA_W-1:0] e2_data1_i,
    input  logic                  e2_valid0_i,
    input  logic                  e2_valid1_i,
    input  logic [`EX_REG_W-1:0]  wb_rd0_i,
    input  logic [`EX_REG_W-1:0]  wb_rd1_i,
    input  logic [`EX_DATA_W-1:0] wb_data0_i,
    input  logic [`EX_DATA_W-1:0] wb_data1_i,
    input  logic                  wb_valid0_i,
    input  logic                  wb_valid1_i,
    output logic [`EX_DATA_W-1:0] rj_data_o,
    output logic [`EX_DATA_W-1:0] rk_data_o
);

    // youngest producer first, r0 is hardwired
    function automatic logic [`EX_DATA_W-1:0] pick(
        input logic [`EX_REG_W-1:0]  addr,
        input logic [`EX_DATA_W-1:0] rf_data
    );
        logic [`EX_DATA_W-1:0] data;
        data = rf_data;
        if (addr != '0) begin
            if (e2_valid1_i && e2_rd1_i == addr)      data = e2_data1_i;
            else if (e2_valid0_i && e2_rd0_i == addr) data = e2_data0_i;
            else if (wb_valid1_i && wb_rd1_i == addr) data = wb_data1_i;
            else if (wb_valid0_i && wb_rd0_i == addr) data = wb_data0_i;
        end
        return data;
    endfunction

    // any live producer for this register
    function automatic logic live_hit(input logic [`EX_REG_W-1:0] addr);
        return (addr != '0) &&
               ((e2_valid1_i && e2_rd1_i == addr) || (e2_valid0_i && e2_rd0_i == addr) ||
                (wb_valid1_i && wb_rd1_i == addr) || (wb_valid0_i && wb_rd0_i == addr));
    endfunction

    always_comb begin
        rj_data_o = pick(rj_i, rj_data_i);
        rk_data_o = pick(rk_i, rk_data_i);
    end

    // bypassed value must come from a valid, nonzero destination
    always_comb begin
        a_fwd_valid: assert final ((rj_data_o == rj_data_i || live_hit(rj_i)) &&
                                   (rk_data_o == rk_data_i || live_hit(rk_i)))
            else $error("operand forwarded without a valid producer");
    end

endmodule

// File: src/ex_pkg.sv
package ex_pkg;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_nor  = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        src1_rf   = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2,
        src1_tid  = 2'd3   // rdcntid
    } src1_sel_e;

    typedef enum logic [1:0] {
        src2_rf     = 2'd0,
        src2_imm    = 2'd1,
        src2_cnt_lo = 2'd2,
        src2_cnt_hi = 2'd3
    } src2_sel_e;

    typedef enum logic [3:0] {
        br_none = 4'd0,
        br_beq  = 4'd1,
        br_bne  = 4'd2,
        br_blt  = 4'd3,
        br_bge  = 4'd4,
        br_bltu = 4'd5,
        br_bgeu = 4'd6,
        br_b    = 4'd7,
        br_jirl = 4'd8    // register-relative target
    } br_op_e;

    typedef enum logic [2:0] {
        div_none = 3'd0,
        div_div  = 3'd1,
        div_mod  = 3'd2,
        div_divu = 3'd3,
        div_modu = 3'd4
    } div_op_e;

    typedef enum logic [1:0] {
        div_idle = 2'd0,
        div_run  = 2'd1,
        div_done = 2'd2
    } div_state_e;

endpackage

// File: src/ex_settings.svh
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// datapath widths
`define EX_DATA_W    32
`define EX_REG_W     5

// one quotient bit per iteration
`define EX_DIV_STEPS `EX_DATA_W

`endif

// File: tb.f
+incdir+src
src/ex_pkg.sv
src/ex_forward.sv
src/ex_alu.sv
src/ex_branch.sv
src/ex_divider.sv
src/ex1_stage.sv
verif/ex1_tb.sv

// File: verif/ex1_tb.sv
`include "ex_settings.svh"

module ex1_tb;

    localparam int N_ALU   = 200;
    localparam int N_SEL   = 60;
    localparam int N_FWD   = 150;
    localparam int N_BR    = 150;
    localparam int N_DIV   = 80;
    localparam int N_FLUSH = 6;
    // a flush round is a held divide plus an idle tail, so it counts twice
    localparam int N_VEC   = N_ALU + N_SEL + N_FWD + N_BR + N_DIV + 2 * N_FLUSH + 1;
    localparam int WATCHDOG_CYCLES = N_VEC * (`EX_DIV_STEPS + 4);

    typedef struct packed {
        logic [31:0] r0;
        logic [31:0] r1;
        logic        taken;
        logic [31:0] tpc;
        logic        dir_fail;
        logic        addr_fail;
        logic        div_req;
        logic [31:0] div_res;
    } expect_t;

    logic clk = 1'b0;
    logic arst_n_i, flush_i, valid0_i, valid1_i, predict_taken_i;
    logic [31:0] pc0_i, pc1_i, imm0_i, imm1_i, tid_i, predict_pc_i;
    logic [4:0]  rj0_i, rk0_i, rj1_i, rk1_i, e2_rd0_i, e2_rd1_i, wb_rd0_i, wb_rd1_i;
    logic [31:0] rj0_data_i, rk0_data_i, rj1_data_i, rk1_data_i;
    logic [31:0] e2_data0_i, e2_data1_i, wb_data0_i, wb_data1_i;
    logic        e2_valid0_i, e2_valid1_i, wb_valid0_i, wb_valid1_i;
    logic [63:0] stable_counter_i;
    ex_pkg::alu_op_e   alu_op0_i, alu_op1_i;
    ex_pkg::src1_sel_e src1_sel0_i, src1_sel1_i;
    ex_pkg::src2_sel_e src2_sel0_i, src2_sel1_i;
    ex_pkg::br_op_e    br_op0_i;
    ex_pkg::div_op_e   div_op0_i;
    logic [31:0] result0_o, result1_o, fact_tpc_o, div_result_o;
    logic        result0_valid_o, result1_valid_o, fact_taken_o;
    logic        predict_dir_fail_o, predict_addr_fail_o, div_done_o, stall_o;

    expect_t     want;
    logic        div_pending;   // a divide was issued and its done pulse is due
    int          div_age;       // rising edges since the divide was issued
    logic        done_exp;
    logic        stall_exp;
    logic [31:0] lcg_state = 32'hce06_ed3e;

    ex1_stage uut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);   // fold weak low bits
    endfunction

    function automatic logic chance(input int unsigned pct);
        return (rand32() % 100) < pct;
    endfunction

    // lowest priority first so later matches override
    function automatic logic [31:0] fwd_ref(input logic [4:0] a, input logic [31:0] rf);
        logic [31:0] v;
        v = rf;
        if (a != 5'd0) begin
            if (wb_valid0_i && wb_rd0_i == a) v = wb_data0_i;
            if (wb_valid1_i && wb_rd1_i == a) v = wb_data1_i;
            if (e2_valid0_i && e2_rd0_i == a) v = e2_data0_i;
            if (e2_valid1_i && e2_rd1_i == a) v = e2_data1_i;
        end
        return v;
    endfunction

    function automatic logic [31:0] alu_ref(input ex_pkg::alu_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [63:0] ext;
        logic        lt;
        ext = {{32{a[31]}}, a} >> b[4:0];
        lt  = (a[31] != b[31]) ? a[31] : (a < b);
        case (op)
            ex_pkg::alu_add:  return a + b;
            ex_pkg::alu_sub:  return a + ~b + 32'd1;
            ex_pkg::alu_slt:  return {31'd0, lt};
            ex_pkg::alu_sltu: return {31'd0, (a < b)};
            ex_pkg::alu_and:  return a & b;
            ex_pkg::alu_or:   return a | b;
            ex_pkg::alu_nor:  return ~a & ~b;
            ex_pkg::alu_xor:  return (a | b) & ~(a & b);
            ex_pkg::alu_sll:  return a << b[4:0];
            ex_pkg::alu_srl:  return a >> b[4:0];
            ex_pkg::alu_sra:  return ext[31:0];
            default:          return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] div_ref(input ex_pkg::div_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
        longint sa;
        longint sb;
        logic   sgn;
        logic   is_mod;
        sgn    = (op == ex_pkg::div_div) || (op == ex_pkg::div_mod);
        is_mod = (op == ex_pkg::div_mod) || (op == ex_pkg::div_modu);
        if (b == 32'd0) return is_mod ? a : 32'hffff_ffff;
        sa = sgn ? longint'($signed(a)) : longint'({32'd0, a});
        sb = sgn ? longint'($signed(b)) : longint'({32'd0, b});
        // 64-bit math keeps the min/-1 case exact
        return is_mod ? 32'(sa % sb) : 32'(sa / sb);
    endfunction

    function automatic expect_t model();
        expect_t     e;
        logic [31:0] rj0, rk0, rj1, rk1, a0, b0, a1, b1;
        logic        cond;
        logic        active;
        rj0 = fwd_ref(rj0_i, rj0_data_i);
        rk0 = fwd_ref(rk0_i, rk0_data_i);
        rj1 = fwd_ref(rj1_i, rj1_data_i);
        rk1 = fwd_ref(rk1_i, rk1_data_i);
        a0 = (src1_sel0_i == ex_pkg::src1_rf) ? rj0 : (src1_sel0_i == ex_pkg::src1_pc) ? pc0_i :
             (src1_sel0_i == ex_pkg::src1_zero) ? 32'd0 : tid_i;
        a1 = (src1_sel1_i == ex_pkg::src1_rf) ? rj1 : (src1_sel1_i == ex_pkg::src1_pc) ? pc1_i :
             (src1_sel1_i == ex_pkg::src1_zero) ? 32'd0 : tid_i;
        b0 = (src2_sel0_i == ex_pkg::src2_rf) ? rk0 : (src2_sel0_i == ex_pkg::src2_imm) ? imm0_i :
             (src2_sel0_i == ex_pkg::src2_cnt_lo) ? stable_counter_i[31:0] : stable_counter_i[63:32];
        b1 = (src2_sel1_i == ex_pkg::src2_rf) ? rk1 : (src2_sel1_i == ex_pkg::src2_imm) ? imm1_i :
             (src2_sel1_i == ex_pkg::src2_cnt_lo) ? stable_counter_i[31:0] : stable_counter_i[63:32];
        e.r0 = (br_op0_i != ex_pkg::br_none) ? pc0_i + 32'd4 : alu_ref(alu_op0_i, a0, b0);
        e.r1 = alu_ref(alu_op1_i, a1, b1);
        case (br_op0_i)
            ex_pkg::br_beq:  cond = (rj0 == rk0);
            ex_pkg::br_bne:  cond = (rj0 != rk0);
            ex_pkg::br_blt:  cond = $signed(rj0) < $signed(rk0);
            ex_pkg::br_bge:  cond = !($signed(rj0) < $signed(rk0));
            ex_pkg::br_bltu: cond = (rj0 < rk0);
            ex_pkg::br_bgeu: cond = !(rj0 < rk0);
            default:         cond = 1'b1;   // b and jirl
        endcase
        active      = valid0_i && (br_op0_i != ex_pkg::br_none);
        e.taken     = active && cond;
        e.tpc       = !active ? 32'd0 :
                      (br_op0_i == ex_pkg::br_jirl) ? rj0 + imm0_i : pc0_i + imm0_i;
        e.dir_fail  = active && (e.taken != predict_taken_i);
        e.addr_fail = e.taken && predict_taken_i && (e.tpc != predict_pc_i);
        e.div_req   = valid0_i && (div_op0_i != ex_pkg::div_none);
        e.div_res   = div_ref(div_op0_i, rj0, rk0);
        return e;
    endfunction

    task automatic compare_value(input logic [31:0] got, input logic [31:0] exp_v,
                                 input string what);
        if (got !== exp_v) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp_v);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    always @(posedge clk) begin
        if (arst_n_i) begin
            // first edge accepts, done is seen on the edge after it rises
            done_exp  = div_pending && (div_age == `EX_DIV_STEPS + 2);
            stall_exp = want.div_req && !done_exp;
            compare_value(32'(div_done_o), 32'(done_exp), "div_done_o");
            compare_value(32'(stall_o), 32'(stall_exp), "stall_o");
            compare_value(result0_o, want.r0, "result0_o");
            compare_value(result1_o, want.r1, "result1_o");
            compare_value(32'(result0_valid_o), 32'(valid0_i && !flush_i && !stall_exp),
                          "result0_valid_o");
            compare_value(32'(result1_valid_o), 32'(valid1_i && !flush_i && !stall_exp),
                          "result1_valid_o");
            compare_value(32'(fact_taken_o), 32'(want.taken), "fact_taken_o");
            compare_value(fact_tpc_o, want.tpc, "fact_tpc_o");
            compare_value(32'(predict_dir_fail_o), 32'(want.dir_fail), "predict_dir_fail_o");
            compare_value(32'(predict_addr_fail_o), 32'(want.addr_fail), "predict_addr_fail_o");
            if (done_exp) compare_value(div_result_o, want.div_res, "div_result_o");
            if (div_pending) div_age = div_age + 1;
        end
    end

    // hang guard
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    task automatic drive_random_lanes();
        pc0_i = rand32() & ~32'd3;
        pc1_i = pc0_i + 32'd4;
        valid0_i = chance(85);
        valid1_i = chance(85);
        alu_op0_i = ex_pkg::alu_op_e'(4'(rand32() % 11));
        alu_op1_i = ex_pkg::alu_op_e'(4'(rand32() % 11));
        src1_sel0_i = ex_pkg::src1_rf;
        src1_sel1_i = ex_pkg::src1_rf;
        src2_sel0_i = chance(50) ? ex_pkg::src2_imm : ex_pkg::src2_rf;
        src2_sel1_i = chance(50) ? ex_pkg::src2_imm : ex_pkg::src2_rf;
        imm0_i = rand32();
        imm1_i = rand32();
        rj0_i = 5'(rand32());
        rk0_i = 5'(rand32());
        rj1_i = 5'(rand32());
        rk1_i = 5'(rand32());
        rj0_data_i = rand32();
        rk0_data_i = rand32();
        rj1_data_i = rand32();
        rk1_data_i = rand32();
        e2_rd0_i = 5'(rand32());
        e2_rd1_i = 5'(rand32());
        wb_rd0_i = 5'(rand32());
        wb_rd1_i = 5'(rand32());
        e2_data0_i = rand32();
        e2_data1_i = rand32();
        wb_data0_i = rand32();
        wb_data1_i = rand32();
        {e2_valid0_i, e2_valid1_i, wb_valid0_i, wb_valid1_i} = 4'b0000;
        tid_i = rand32();
        stable_counter_i = {rand32(), rand32()};
        br_op0_i = ex_pkg::br_none;
        predict_taken_i = 1'b0;
        predict_pc_i = 32'd0;
        div_op0_i = ex_pkg::div_none;
        flush_i = 1'b0;
    endtask

    // inputs are set, hold them through a divide
    task automatic launch();
        want = model();
        div_pending = want.div_req;
        div_age = 0;
        if (want.div_req) begin
            do @(negedge clk); while (!div_done_o);
        end
    endtask

    task automatic run_alu_vectors();
        repeat (N_ALU) begin
            @(negedge clk);
            drive_random_lanes();
            flush_i = chance(12);
            launch();
        end
    endtask

    task automatic run_select_vectors();
        repeat (N_SEL) begin
            @(negedge clk);
            drive_random_lanes();
            src1_sel0_i = ex_pkg::src1_sel_e'(2'(rand32()));
            src1_sel1_i = ex_pkg::src1_sel_e'(2'(rand32()));
            src2_sel0_i = ex_pkg::src2_sel_e'(2'(rand32()));
            src2_sel1_i = ex_pkg::src2_sel_e'(2'(rand32()));
            launch();
        end
    endtask

    task automatic run_forward_vectors();
        repeat (N_FWD) begin
            @(negedge clk);
            drive_random_lanes();
            // small register range to force collisions and r0 hits
            {rj0_i, rk0_i} = {5'(rand32() % 4), 5'(rand32() % 4)};
            {rj1_i, rk1_i} = {5'(rand32() % 4), 5'(rand32() % 4)};
            {e2_rd0_i, e2_rd1_i} = {5'(rand32() % 4), 5'(rand32() % 4)};
            {wb_rd0_i, wb_rd1_i} = {5'(rand32() % 4), 5'(rand32() % 4)};
            {e2_valid0_i, e2_valid1_i} = {chance(60), chance(60)};
            {wb_valid0_i, wb_valid1_i} = {chance(60), chance(60)};
            launch();
        end
    endtask

    task automatic run_branch_vectors();
        repeat (N_BR) begin
            @(negedge clk);
            drive_random_lanes();
            br_op0_i = ex_pkg::br_op_e'(4'(rand32() % 9));
            if (chance(35)) rk0_data_i = rj0_data_i;
            else if (chance(30)) rk0_data_i = rj0_data_i ^ 32'h8000_0000;   // sign flip
            predict_taken_i = chance(50);
            if (chance(50)) begin
                predict_pc_i = (br_op0_i == ex_pkg::br_jirl) ? rj0_data_i + imm0_i
                                                             : pc0_i + imm0_i;
            end else begin
                predict_pc_i = rand32();
            end
            launch();
        end
    endtask

    task automatic pick_div_operands();
        case (rand32() % 4)
            0: rj0_data_i = rand32();
            1: rj0_data_i = rand32() % 1000;
            2: rj0_data_i = -(rand32() % 1000);
            default: rj0_data_i = 32'h8000_0000;
        endcase
        case (rand32() % 5)
            0: rk0_data_i = rand32();
            1: rk0_data_i = rand32() % 16;   // zero now and then
            2: rk0_data_i = -(rand32() % 50);
            3: rk0_data_i = 32'd0;
            default: rk0_data_i = 32'hffff_ffff;
        endcase
    endtask

    task automatic run_divide_vectors();
        repeat (N_DIV) begin
            @(negedge clk);
            drive_random_lanes();
            valid0_i = 1'b1;
            div_op0_i = ex_pkg::div_op_e'(3'(rand32() % 4 + 1));
            pick_div_operands();
            launch();
        end
    endtask

    task automatic run_flush_divides();
        int unsigned hold;
        repeat (N_FLUSH) begin
            @(negedge clk);
            drive_random_lanes();
            valid0_i = 1'b1;
            div_op0_i = ex_pkg::div_op_e'(3'(rand32() % 4 + 1));
            pick_div_operands();
            want = model();
            div_pending = 1'b1;
            div_age = 0;
            hold = 3 + rand32() % 8;
            repeat (hold) @(negedge clk);
            flush_i = 1'b1;
            valid0_i = 1'b0;
            div_op0_i = ex_pkg::div_none;
            want = model();
            div_pending = 1'b0;
            @(negedge clk);
            flush_i = 1'b0;
            want = model();
            compare_value(32'(stall_o), 32'd0, "stall_o after flush");
            compare_value(32'(div_done_o), 32'd0, "div_done_o after flush");
            repeat (`EX_DIV_STEPS + 4) @(negedge clk);   // no late done pulse
        end
    endtask

    initial begin
        arst_n_i = 1'b0;
        drive_random_lanes();
        {valid0_i, valid1_i} = 2'b00;
        want = model();
        div_pending = 1'b0;
        div_age = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        compare_value(32'(stall_o), 32'd0, "stall_o after reset");
        compare_value(32'(div_done_o), 32'd0, "div_done_o after reset");
        run_alu_vectors();
        run_select_vectors();
        run_forward_vectors();
        run_branch_vectors();
        run_divide_vectors();
        run_flush_divides();
        @(negedge clk);
        $display("Regression passed");
        $finish;
    end

endmodule
